/* src/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // Default data word width, address words are twice as wide
    parameter int EX_DATA_W = 24;

    // Execute stage opcodes
    typedef enum logic [4:0] {
        EX_NOP    = 5'd0,
        EX_LUI,
        // Unsigned register-register
        EX_MOV_UR,
        EX_ADD_UR,
        EX_SUB_UR,
        EX_AND_UR,
        EX_OR_UR,
        EX_XOR_UR,
        EX_SHL_UR,
        EX_SHR_UR,
        EX_CMP_UR,
        // Signed register-register
        EX_ADD_SR,
        EX_SUB_SR,
        EX_CMP_SR,
        // Unsigned immediate, upper bits from bank0
        EX_MOV_UI,
        EX_ADD_UI,
        EX_SUB_UI,
        EX_CMP_UI,
        // Conditional branches
        EX_JCC_UI,
        EX_BCC_SO
    } ex_opc_e;

    // Branch condition codes
    typedef enum logic [3:0] {
        CC_RA = 4'd0,
        CC_EQ,
        CC_NE,
        CC_LT,
        CC_GT,
        CC_GE,
        CC_LE,
        CC_BT,
        CC_AT,
        CC_BE,
        CC_AE
    } ex_cc_e;

    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } ex_flags_t;

endpackage

`default_nettype wire

/* src/ex_result_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Combinational results of one execute cycle, on their way to the stage register
interface ex_result_if #(
    parameter int DATA_W = ex_pkg::EX_DATA_W
);
    logic [DATA_W-1:0]   result;
    ex_pkg::ex_flags_t   flags;
    logic                flags_we;
    logic                branch_taken;
    logic [2*DATA_W-1:0] branch_pc;

    modport alu_mp (
        output result,
        output flags,
        output flags_we
    );

    modport branch_mp (
        output branch_taken,
        output branch_pc
    );

    modport reg_mp (
        input result,
        input flags,
        input flags_we,
        input branch_taken,
        input branch_pc
    );

endinterface

`default_nettype wire

/* src/ex_uimm_banks.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_uimm_banks #(
    parameter int DATA_W = ex_pkg::EX_DATA_W
) (
    input  wire                      iw_clk,
    input  wire                      iw_rst,
    input  wire                      stall,
    input  wire                      flush,
    input  wire ex_pkg::ex_opc_e     opc,
    input  wire  [DATA_W/2-1:0]      imm12,
    input  wire  [1:0]               uimm_bank,
    output logic [DATA_W-1:0]        imm_word,
    output logic [3*(DATA_W/2)-1:0]  upper_addr
);
    localparam int HALF_W = DATA_W / 2;

    logic [HALF_W-1:0] bank0;
    logic [HALF_W-1:0] bank1;
    logic [HALF_W-1:0] bank2;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            bank0 <= '0;
            bank1 <= '0;
            bank2 <= '0;
        end else if (flush) begin
            // Drop partial constants from the squashed path
            bank0 <= '0;
            bank1 <= '0;
            bank2 <= '0;
        end else if (!stall && opc == ex_pkg::EX_LUI) begin
            case (uimm_bank)
                2'd1:    bank1 <= imm12;
                2'd2:    bank2 <= imm12;
                default: bank0 <= imm12;
            endcase
        end
    end

    assign imm_word   = {bank0, imm12};
    assign upper_addr = {bank2, bank1, bank0};

    // Bank code 3 is reserved, the decoder must not issue it
    a_lui_bank_code: assert property (@(posedge iw_clk) disable iff (iw_rst)
        opc == ex_pkg::EX_LUI |-> uimm_bank != 2'd3)
        else $error("ex_uimm_banks: LUI with reserved bank code 3");

endmodule

`default_nettype wire

/* src/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu #(
    parameter int DATA_W = ex_pkg::EX_DATA_W
) (
    input  wire ex_pkg::ex_opc_e  opc,
    input  wire  [DATA_W-1:0]     src_val,
    input  wire  [DATA_W-1:0]     tgt_val,
    input  wire  [DATA_W-1:0]     imm_word,
    ex_result_if.alu_mp           res
);
    logic              use_imm;
    logic [DATA_W-1:0] opb;
    logic [DATA_W:0]   sum;
    logic [DATA_W:0]   diff;
    logic              add_v;
    logic              sub_v;
    logic [4:0]        shamt;
    logic              over_shift;
    logic [DATA_W:0]   shl_wide;
    logic [DATA_W:0]   shr_wide;
    logic [DATA_W-1:0] alu_result;
    ex_pkg::ex_flags_t alu_flags;
    logic              alu_flags_we;

    // Immediate forms replace src with {bank0, imm12}
    assign use_imm = opc inside {ex_pkg::EX_MOV_UI, ex_pkg::EX_ADD_UI,
                                 ex_pkg::EX_SUB_UI, ex_pkg::EX_CMP_UI};
    assign opb     = use_imm ? imm_word : src_val;

    // One adder and one subtractor shared by all arithmetic forms
    assign sum   = {1'b0, opb} + {1'b0, tgt_val};
    assign diff  = {1'b0, tgt_val} - {1'b0, opb};
    assign add_v = (opb[DATA_W-1] == tgt_val[DATA_W-1]) &&
                   (sum[DATA_W-1] != opb[DATA_W-1]);
    assign sub_v = (opb[DATA_W-1] != tgt_val[DATA_W-1]) &&
                   (diff[DATA_W-1] != tgt_val[DATA_W-1]);

    // Extra bit on each side catches the last bit shifted out
    assign shamt      = src_val[4:0];
    assign over_shift = int'(shamt) >= DATA_W;
    assign shl_wide   = {1'b0, tgt_val} << shamt;
    assign shr_wide   = {tgt_val, 1'b0} >> shamt;

    always_comb begin
        alu_result   = '0;
        alu_flags    = '0;
        alu_flags_we = 1'b0;
        case (opc)
            ex_pkg::EX_MOV_UR, ex_pkg::EX_MOV_UI: begin
                alu_result   = opb;
                alu_flags.z  = (opb == '0);
                alu_flags_we = 1'b1;
            end
            ex_pkg::EX_ADD_UR, ex_pkg::EX_ADD_UI, ex_pkg::EX_ADD_SR: begin
                alu_result   = sum[DATA_W-1:0];
                alu_flags.z  = (sum[DATA_W-1:0] == '0);
                alu_flags.c  = sum[DATA_W];
                alu_flags_we = 1'b1;
                if (opc == ex_pkg::EX_ADD_SR) begin
                    alu_flags.n = sum[DATA_W-1];
                    alu_flags.v = add_v;
                end
            end
            ex_pkg::EX_SUB_UR, ex_pkg::EX_SUB_UI, ex_pkg::EX_SUB_SR: begin
                alu_result   = diff[DATA_W-1:0];
                alu_flags.z  = (diff[DATA_W-1:0] == '0);
                // Borrow out means tgt < operand
                alu_flags.c  = diff[DATA_W];
                alu_flags_we = 1'b1;
                if (opc == ex_pkg::EX_SUB_SR) begin
                    alu_flags.n = diff[DATA_W-1];
                    alu_flags.v = sub_v;
                end
            end
            ex_pkg::EX_AND_UR: begin
                alu_result   = src_val & tgt_val;
                alu_flags.z  = ((src_val & tgt_val) == '0);
                alu_flags_we = 1'b1;
            end
            ex_pkg::EX_OR_UR: begin
                alu_result   = src_val | tgt_val;
                alu_flags.z  = ((src_val | tgt_val) == '0);
                alu_flags_we = 1'b1;
            end
            ex_pkg::EX_XOR_UR: begin
                alu_result   = src_val ^ tgt_val;
                alu_flags.z  = ((src_val ^ tgt_val) == '0);
                alu_flags_we = 1'b1;
            end
            ex_pkg::EX_SHL_UR, ex_pkg::EX_SHR_UR: begin
                if (over_shift) begin
                    alu_flags.z = 1'b1;
                end else if (opc == ex_pkg::EX_SHL_UR) begin
                    alu_result  = shl_wide[DATA_W-1:0];
                    alu_flags.c = shl_wide[DATA_W];
                    alu_flags.z = (shl_wide[DATA_W-1:0] == '0);
                end else begin
                    alu_result  = shr_wide[DATA_W:1];
                    alu_flags.c = shr_wide[0];
                    alu_flags.z = (shr_wide[DATA_W:1] == '0);
                end
                // A zero source word leaves the flags alone
                alu_flags_we = (src_val != '0);
            end
            ex_pkg::EX_CMP_UR, ex_pkg::EX_CMP_UI: begin
                alu_flags.z  = (opb == tgt_val);
                alu_flags.c  = (opb < tgt_val);
                alu_flags_we = 1'b1;
            end
            ex_pkg::EX_CMP_SR: begin
                alu_flags.z  = (diff[DATA_W-1:0] == '0);
                alu_flags.n  = diff[DATA_W-1];
                alu_flags.v  = sub_v;
                alu_flags_we = 1'b1;
            end
            default: begin
                // NOP, LUI and branches produce no result and no flags
            end
        endcase
    end

    assign res.result   = alu_result;
    assign res.flags    = alu_flags;
    assign res.flags_we = alu_flags_we;

endmodule

`default_nettype wire

/* src/ex_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit #(
    parameter int DATA_W = ex_pkg::EX_DATA_W
) (
    input  wire ex_pkg::ex_opc_e     opc,
    input  wire ex_pkg::ex_cc_e      cc,
    input  wire ex_pkg::ex_flags_t   flags_in,
    input  wire  [2*DATA_W-1:0]      pc,
    input  wire  [DATA_W/2-1:0]      imm12,
    input  wire  [3*(DATA_W/2)-1:0]  upper_addr,
    ex_result_if.branch_mp           res
);
    localparam int ADDR_W = 2 * DATA_W;
    localparam int HALF_W = DATA_W / 2;

    logic              nv;
    logic              cond_ok;
    logic              is_branch;
    logic              taken;
    logic [ADDR_W-1:0] abs_target;
    logic [ADDR_W-1:0] rel_target;

    // Signed less-than from the incoming flags
    assign nv = flags_in.n ^ flags_in.v;

    always_comb begin
        case (cc)
            ex_pkg::CC_RA: cond_ok = 1'b1;
            ex_pkg::CC_EQ: cond_ok = flags_in.z;
            ex_pkg::CC_NE: cond_ok = !flags_in.z;
            ex_pkg::CC_LT: cond_ok = nv;
            ex_pkg::CC_GT: cond_ok = !flags_in.z && !nv;
            ex_pkg::CC_GE: cond_ok = !nv;
            ex_pkg::CC_LE: cond_ok = flags_in.z || nv;
            ex_pkg::CC_BT: cond_ok = flags_in.c;
            ex_pkg::CC_AT: cond_ok = !flags_in.c && !flags_in.z;
            ex_pkg::CC_BE: cond_ok = flags_in.c || flags_in.z;
            ex_pkg::CC_AE: cond_ok = !flags_in.c;
            default:       cond_ok = 1'b0;
        endcase
    end

    assign is_branch  = (opc == ex_pkg::EX_JCC_UI) || (opc == ex_pkg::EX_BCC_SO);
    assign taken      = is_branch && cond_ok;
    assign abs_target = {upper_addr, imm12};
    assign rel_target = pc + {{(ADDR_W-HALF_W){imm12[HALF_W-1]}}, imm12};

    assign res.branch_taken = taken;
    assign res.branch_pc    = !taken                        ? '0 :
                              (opc == ex_pkg::EX_JCC_UI)    ? abs_target : rel_target;

endmodule

`default_nettype wire

/* src/ex_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg #(
    parameter int DATA_W = ex_pkg::EX_DATA_W
) (
    input  wire                       iw_clk,
    input  wire                       iw_rst,
    input  wire                       stall,
    input  wire                       flush,
    input  wire ex_pkg::ex_opc_e      opc,
    input  wire                       rd_we,
    ex_result_if.reg_mp               res,
    output ex_pkg::ex_opc_e           opc_out,
    output logic                      rd_we_out,
    output logic [DATA_W-1:0]         result,
    output ex_pkg::ex_flags_t         flags,
    output logic                      flags_we,
    output logic                      branch_taken,
    output logic [2*DATA_W-1:0]       branch_pc
);

    // Flush wins over stall, stall holds every field
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            opc_out      <= ex_pkg::EX_NOP;
            rd_we_out    <= 1'b0;
            result       <= '0;
            flags        <= '0;
            flags_we     <= 1'b0;
            branch_taken <= 1'b0;
            branch_pc    <= '0;
        end else if (flush) begin
            opc_out      <= ex_pkg::EX_NOP;
            rd_we_out    <= 1'b0;
            result       <= '0;
            flags        <= '0;
            flags_we     <= 1'b0;
            branch_taken <= 1'b0;
            branch_pc    <= '0;
        end else if (!stall) begin
            opc_out      <= opc;
            rd_we_out    <= rd_we;
            result       <= res.result;
            flags        <= res.flags;
            flags_we     <= res.flags_we;
            branch_taken <= res.branch_taken;
            branch_pc    <= res.branch_pc;
        end
    end

    // A flushed slot must not write anything or redirect fetch
    a_flush_empties: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> !branch_taken && !flags_we && !rd_we_out)
        else $error("ex_pipe_reg: side effects left after flush");

endmodule

`default_nettype wire

/* src/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
    parameter int DATA_W = ex_pkg::EX_DATA_W
) (
    input  wire                      iw_clk,
    input  wire                      iw_rst,
    input  wire                      stall,
    input  wire                      flush,
    input  wire ex_pkg::ex_opc_e     opc,
    input  wire ex_pkg::ex_cc_e      cc,
    input  wire  [2*DATA_W-1:0]      pc,
    input  wire  [DATA_W-1:0]        src_val,
    input  wire  [DATA_W-1:0]        tgt_val,
    input  wire  [DATA_W/2-1:0]      imm12,
    input  wire  [1:0]               uimm_bank,
    input  wire ex_pkg::ex_flags_t   flags_in,
    input  wire                      rd_we,
    output wire ex_pkg::ex_opc_e     opc_out,
    output wire                      rd_we_out,
    output wire  [DATA_W-1:0]        result,
    output wire ex_pkg::ex_flags_t   flags,
    output wire                      flags_we,
    output wire                      branch_taken,
    output wire  [2*DATA_W-1:0]      branch_pc
);
    logic [DATA_W-1:0]       imm_word;
    logic [3*(DATA_W/2)-1:0] upper_addr;

    ex_result_if #(.DATA_W(DATA_W)) res_if ();

    ex_uimm_banks #(.DATA_W(DATA_W)) u_banks (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .stall      (stall),
        .flush      (flush),
        .opc        (opc),
        .imm12      (imm12),
        .uimm_bank  (uimm_bank),
        .imm_word   (imm_word),
        .upper_addr (upper_addr)
    );

    ex_alu #(.DATA_W(DATA_W)) u_alu (
        .opc      (opc),
        .src_val  (src_val),
        .tgt_val  (tgt_val),
        .imm_word (imm_word),
        .res      (res_if.alu_mp)
    );

    ex_branch_unit #(.DATA_W(DATA_W)) u_branch (
        .opc        (opc),
        .cc         (cc),
        .flags_in   (flags_in),
        .pc         (pc),
        .imm12      (imm12),
        .upper_addr (upper_addr),
        .res        (res_if.branch_mp)
    );

    ex_pipe_reg #(.DATA_W(DATA_W)) u_pipe_reg (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .flush        (flush),
        .opc          (opc),
        .rd_we        (rd_we),
        .res          (res_if.reg_mp),
        .opc_out      (opc_out),
        .rd_we_out    (rd_we_out),
        .result       (result),
        .flags        (flags),
        .flags_we     (flags_we),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

endmodule

`default_nettype wire

/* bench/ex_tb_tests.svh */
// Expected ALU response from the operation rules
// For immediate forms op_b is already {bank0, imm12}
task automatic alu_expect(input ex_pkg::ex_opc_e op, input logic [DATA_W-1:0] op_b,
                          input logic [DATA_W-1:0] tgt, output logic [DATA_W-1:0] res,
                          output ex_pkg::ex_flags_t fl, output logic we);
    longint full;
    longint sa;
    longint sb;
    longint s;
    int     n;
    logic   alu_op;
    res    = '0;
    fl     = '0;
    alu_op = !(op inside {ex_pkg::EX_NOP, ex_pkg::EX_LUI,
                          ex_pkg::EX_JCC_UI, ex_pkg::EX_BCC_SO});
    we     = alu_op;
    full   = longint'(1) << DATA_W;
    sa     = tgt[DATA_W-1] ? longint'(tgt) - full : longint'(tgt);
    sb     = op_b[DATA_W-1] ? longint'(op_b) - full : longint'(op_b);
    case (op)
        ex_pkg::EX_MOV_UR, ex_pkg::EX_MOV_UI: res = op_b;
        ex_pkg::EX_AND_UR: res = op_b & tgt;
        ex_pkg::EX_OR_UR:  res = op_b | tgt;
        ex_pkg::EX_XOR_UR: res = op_b ^ tgt;
        ex_pkg::EX_ADD_UR, ex_pkg::EX_ADD_UI, ex_pkg::EX_ADD_SR: begin
            s    = longint'(op_b) + longint'(tgt);
            res  = s[DATA_W-1:0];
            fl.c = (s >= full);
        end
        ex_pkg::EX_SUB_UR, ex_pkg::EX_SUB_UI, ex_pkg::EX_SUB_SR: begin
            res  = tgt - op_b;
            fl.c = (tgt < op_b);
        end
        ex_pkg::EX_CMP_UR, ex_pkg::EX_CMP_UI: fl.c = (op_b < tgt);
        ex_pkg::EX_SHL_UR, ex_pkg::EX_SHR_UR: begin
            n  = int'(op_b[4:0]);
            we = (op_b != '0);
            if (n < DATA_W && op == ex_pkg::EX_SHL_UR) begin
                res = tgt << n;
                if (n > 0) fl.c = tgt[DATA_W-n];
            end else if (n < DATA_W) begin
                res = tgt >> n;
                if (n > 0) fl.c = tgt[n-1];
            end
        end
        default: res = '0;
    endcase
    if (op inside {ex_pkg::EX_CMP_UR, ex_pkg::EX_CMP_UI, ex_pkg::EX_CMP_SR}) begin
        fl.z = (op_b == tgt);
    end else if (alu_op) begin
        fl.z = (res == '0);
    end
    // True signed result whose low bits match the wrapped word
    s = (op == ex_pkg::EX_ADD_SR) ? sa + sb : sa - sb;
    if (op inside {ex_pkg::EX_ADD_SR, ex_pkg::EX_SUB_SR, ex_pkg::EX_CMP_SR}) begin
        fl.n = s[DATA_W-1];
        fl.v = (s >= full / 2) || (s < -(full / 2));
    end
endtask

function automatic logic cond_holds(input ex_pkg::ex_cc_e c, input ex_pkg::ex_flags_t f);
    logic lt;
    lt = f.n ^ f.v;
    case (c)
        ex_pkg::CC_RA: return 1'b1;
        ex_pkg::CC_EQ: return f.z;
        ex_pkg::CC_NE: return !f.z;
        ex_pkg::CC_LT: return lt;
        ex_pkg::CC_GE: return !lt;
        ex_pkg::CC_GT: return !f.z && !lt;
        ex_pkg::CC_LE: return f.z || lt;
        ex_pkg::CC_BT: return f.c;
        ex_pkg::CC_AE: return !f.c;
        ex_pkg::CC_AT: return !f.c && !f.z;
        ex_pkg::CC_BE: return f.c || f.z;
        default:       return 1'b0;
    endcase
endfunction

task automatic run_op(input ex_pkg::ex_opc_e op, input logic [DATA_W-1:0] src,
                      input logic [DATA_W-1:0] tgt, input logic [HALF_W-1:0] imm);
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] exp_res;
    ex_pkg::ex_flags_t exp_fl;
    logic              exp_we;
    op_b = (op inside {ex_pkg::EX_MOV_UI, ex_pkg::EX_ADD_UI, ex_pkg::EX_SUB_UI,
                       ex_pkg::EX_CMP_UI}) ? {bank_exp[0], imm} : src;
    alu_expect(op, op_b, tgt, exp_res, exp_fl, exp_we);
    drive_op(op, src, tgt, imm);
    wait_capture(op);
    check_data("result", result, exp_res);
    check_flags("flags", flags, exp_fl);
    check_bit("flags_we", flags_we, exp_we);
    check_bit("rd_we_out", rd_we_out, rd_we);
    check_bit("branch_taken", branch_taken, 1'b0);
endtask

task automatic do_lui(input logic [1:0] bank, input logic [HALF_W-1:0] val);
    uimm_bank = bank;
    drive_op(ex_pkg::EX_LUI, rand_word(), rand_word(), val);
    wait_capture(ex_pkg::EX_LUI);
    bank_exp[bank] = val;
    check_data("result", result, '0);
    check_bit("flags_we", flags_we, 1'b0);
endtask

task automatic do_branch(input ex_pkg::ex_opc_e op, input ex_pkg::ex_cc_e c,
                         input ex_pkg::ex_flags_t f, input logic [HALF_W-1:0] imm);
    logic [ADDR_W-1:0] pc_v;
    logic [ADDR_W-1:0] exp_pc;
    logic [63:0]       sum64;
    longint            off;
    logic              exp_taken;
    pc_v      = rand_addr();
    exp_taken = cond_holds(c, f);
    off       = longint'(imm);
    if (imm[HALF_W-1]) begin
        off = off - (longint'(1) << HALF_W);
    end
    sum64 = 64'(pc_v) + 64'(off);
    if (op == ex_pkg::EX_JCC_UI) begin
        exp_pc = {bank_exp[2], bank_exp[1], bank_exp[0], imm};
    end else begin
        exp_pc = sum64[ADDR_W-1:0];
    end
    cc       = c;
    flags_in = f;
    pc       = pc_v;
    drive_op(op, rand_word(), rand_word(), imm);
    wait_capture(op);
    check_bit("branch_taken", branch_taken, exp_taken);
    if (exp_taken) begin
        check_addr("branch_pc", branch_pc, exp_pc);
    end
    check_bit("flags_we", flags_we, 1'b0);
    check_data("result", result, '0);
endtask

task automatic reset_state_test();
    check_opc("opc_out", opc_out, ex_pkg::EX_NOP);
    check_bit("rd_we_out", rd_we_out, 1'b0);
    check_bit("flags_we", flags_we, 1'b0);
    check_bit("branch_taken", branch_taken, 1'b0);
    check_data("result", result, '0);
    check_flags("flags", flags, '0);
    check_addr("branch_pc", branch_pc, '0);
endtask

task automatic unsigned_ops_test();
    ex_pkg::ex_opc_e ops [9] = '{ex_pkg::EX_MOV_UR, ex_pkg::EX_ADD_UR, ex_pkg::EX_SUB_UR,
                                 ex_pkg::EX_AND_UR, ex_pkg::EX_OR_UR, ex_pkg::EX_XOR_UR,
                                 ex_pkg::EX_SHL_UR, ex_pkg::EX_SHR_UR, ex_pkg::EX_CMP_UR};
    for (int i = 0; i < 9; i++) begin
        for (int k = 0; k < 8; k++) begin
            run_op(ops[i], rand_word(), rand_word(), rand_half());
        end
    end
    // Count of zero with flags written, then src of zero with no flag write
    run_op(ex_pkg::EX_SHL_UR, 24'h000020, rand_word(), '0);
    run_op(ex_pkg::EX_SHR_UR, 24'h000000, rand_word(), '0);
    run_op(ex_pkg::EX_SHL_UR, 24'h000018, rand_word(), '0);
    run_op(ex_pkg::EX_SHR_UR, 24'h00001f, rand_word(), '0);
    run_op(ex_pkg::EX_SHL_UR, 24'h000001, 24'h800000, '0);
    run_op(ex_pkg::EX_SHR_UR, 24'h000017, 24'h400000, '0);
    run_op(ex_pkg::EX_CMP_UR, 24'h00abcd, 24'h00abcd, '0);
    run_op(ex_pkg::EX_ADD_UR, 24'hffffff, 24'h000001, '0);
    run_op(ex_pkg::EX_SUB_UR, 24'h000001, 24'h000000, '0);
endtask

task automatic signed_ops_test();
    run_op(ex_pkg::EX_ADD_SR, 24'h000001, 24'h7fffff, '0);
    run_op(ex_pkg::EX_ADD_SR, 24'h800000, 24'h800000, '0);
    run_op(ex_pkg::EX_ADD_SR, 24'hffffff, 24'h000001, '0);
    run_op(ex_pkg::EX_SUB_SR, 24'h000001, 24'h800000, '0);
    run_op(ex_pkg::EX_SUB_SR, 24'hffffff, 24'h7fffff, '0);
    run_op(ex_pkg::EX_CMP_SR, 24'h000001, 24'h800000, '0);
    run_op(ex_pkg::EX_CMP_SR, 24'h123456, 24'h123456, '0);
    run_op(ex_pkg::EX_CMP_SR, 24'h000005, 24'h000003, '0);
    for (int k = 0; k < 8; k++) begin
        run_op(ex_pkg::EX_ADD_SR, rand_word(), rand_word(), '0);
        run_op(ex_pkg::EX_SUB_SR, rand_word(), rand_word(), '0);
        run_op(ex_pkg::EX_CMP_SR, rand_word(), rand_word(), '0);
    end
endtask

task automatic lui_immediate_test();
    logic [HALF_W-1:0] imm;
    do_lui(2'd0, rand_half());
    do_lui(2'd1, rand_half());
    do_lui(2'd2, rand_half());
    for (int k = 0; k < 4; k++) begin
        run_op(ex_pkg::EX_MOV_UI, rand_word(), rand_word(), rand_half());
        run_op(ex_pkg::EX_ADD_UI, rand_word(), rand_word(), rand_half());
        run_op(ex_pkg::EX_SUB_UI, rand_word(), rand_word(), rand_half());
        run_op(ex_pkg::EX_CMP_UI, rand_word(), rand_word(), rand_half());
    end
    // Equal compare against the assembled immediate
    imm = rand_half();
    run_op(ex_pkg::EX_CMP_UI, rand_word(), {bank_exp[0], imm}, imm);
    do_branch(ex_pkg::EX_JCC_UI, ex_pkg::CC_RA, ex_pkg::ex_flags_t'(4'b0000), rand_half());
    do_branch(ex_pkg::EX_JCC_UI, ex_pkg::CC_EQ, ex_pkg::ex_flags_t'(4'b0001), rand_half());
    do_branch(ex_pkg::EX_JCC_UI, ex_pkg::CC_EQ, ex_pkg::ex_flags_t'(4'b1110), rand_half());
endtask

task automatic cond_branch_test();
    for (int k = 0; k < 11; k++) begin
        for (int f = 0; f < 16; f++) begin
            do_branch(ex_pkg::EX_BCC_SO, ex_pkg::ex_cc_e'(k[3:0]),
                      ex_pkg::ex_flags_t'(f[3:0]), rand_half());
        end
    end
endtask

task automatic stall_flush_test();
    logic [DATA_W-1:0] a_src;
    logic [DATA_W-1:0] a_tgt;
    logic [DATA_W-1:0] s_src;
    logic [DATA_W-1:0] s_tgt;
    logic [DATA_W-1:0] held_res;
    ex_pkg::ex_flags_t held_fl;
    logic              held_we;
    logic              held_rd;
    logic [DATA_W-1:0] exp_res;
    ex_pkg::ex_flags_t exp_fl;
    logic              exp_we;
    logic [HALF_W-1:0] imm;
    a_src = rand_word();
    a_tgt = rand_word();
    run_op(ex_pkg::EX_ADD_UR, a_src, a_tgt, '0);
    alu_expect(ex_pkg::EX_ADD_UR, a_src, a_tgt, held_res, held_fl, held_we);
    held_rd  = rd_we;
    s_src    = rand_word();
    s_tgt    = rand_word();
    stall    = 1'b1;
    drive_op(ex_pkg::EX_XOR_UR, s_src, s_tgt, '0);
    for (int i = 0; i < 5; i++) begin
        @(negedge iw_clk);
        check_opc("opc_out", opc_out, ex_pkg::EX_ADD_UR);
        check_data("result", result, held_res);
        check_flags("flags", flags, held_fl);
        check_bit("flags_we", flags_we, held_we);
        check_bit("rd_we_out", rd_we_out, held_rd);
    end
    stall = 1'b0;
    wait_capture(ex_pkg::EX_XOR_UR);
    alu_expect(ex_pkg::EX_XOR_UR, s_src, s_tgt, exp_res, exp_fl, exp_we);
    check_data("result", result, exp_res);
    check_flags("flags", flags, exp_fl);
    // Nonzero bank0 and a live result, then a flush while stalled must empty everything
    do_lui(2'd0, rand_half() | 12'h001);
    run_op(ex_pkg::EX_ADD_UR, 24'hffffff, 24'h000002, '0);
    stall = 1'b1;
    flush = 1'b1;
    drive_op(ex_pkg::EX_MOV_UR, rand_word(), rand_word(), '0);
    wait_capture(ex_pkg::EX_NOP);
    check_bit("rd_we_out", rd_we_out, 1'b0);
    check_bit("flags_we", flags_we, 1'b0);
    check_bit("branch_taken", branch_taken, 1'b0);
    check_data("result", result, '0);
    check_flags("flags", flags, '0);
    check_addr("branch_pc", branch_pc, '0);
    stall    = 1'b0;
    flush    = 1'b0;
    bank_exp = '{default: '0};
    imm      = rand_half();
    run_op(ex_pkg::EX_MOV_UI, rand_word(), rand_word(), imm);
    check_data("result", result, {{(DATA_W-HALF_W){1'b0}}, imm});
endtask

/* bench/ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_tb;
    localparam int DATA_W     = ex_pkg::EX_DATA_W;
    localparam int ADDR_W     = 2 * DATA_W;
    localparam int HALF_W     = DATA_W / 2;
    localparam int WAIT_LIMIT = 8;

    logic              iw_clk;
    logic              iw_rst;
    logic              stall;
    logic              flush;
    ex_pkg::ex_opc_e   opc;
    ex_pkg::ex_cc_e    cc;
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] src_val;
    logic [DATA_W-1:0] tgt_val;
    logic [HALF_W-1:0] imm12;
    logic [1:0]        uimm_bank;
    ex_pkg::ex_flags_t flags_in;
    logic              rd_we;
    ex_pkg::ex_opc_e   opc_out;
    logic              rd_we_out;
    logic [DATA_W-1:0] result;
    ex_pkg::ex_flags_t flags;
    logic              flags_we;
    logic              branch_taken;
    logic [ADDR_W-1:0] branch_pc;

    integer            seed;
    int                errors;
    int                tests_ok;
    int                tests_bad;
    // Expected contents of the three LUI banks
    logic [HALF_W-1:0] bank_exp [3];

    ex_top #(.DATA_W(DATA_W)) dut_i (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .stall        (stall),
        .flush        (flush),
        .opc          (opc),
        .cc           (cc),
        .pc           (pc),
        .src_val      (src_val),
        .tgt_val      (tgt_val),
        .imm12        (imm12),
        .uimm_bank    (uimm_bank),
        .flags_in     (flags_in),
        .rd_we        (rd_we),
        .opc_out      (opc_out),
        .rd_we_out    (rd_we_out),
        .result       (result),
        .flags        (flags),
        .flags_we     (flags_we),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    initial begin
        iw_clk = 1'b0;
        forever #50 iw_clk = ~iw_clk;
    end

    function automatic logic [DATA_W-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    function automatic logic [HALF_W-1:0] rand_half();
        logic [31:0] r;
        r = $random(seed);
        return r[HALF_W-1:0];
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] both;
        hi   = $random(seed);
        lo   = $random(seed);
        both = {hi, lo};
        return both[ADDR_W-1:0];
    endfunction

    // Called right after a falling edge, rd_we is a random pass-through bit
    task automatic drive_op(input ex_pkg::ex_opc_e op, input logic [DATA_W-1:0] src,
                            input logic [DATA_W-1:0] tgt, input logic [HALF_W-1:0] imm);
        logic [31:0] r;
        r       = $random(seed);
        opc     = op;
        src_val = src;
        tgt_val = tgt;
        imm12   = imm;
        rd_we   = r[0];
    endtask

    // At least one edge, then until the expected opcode leaves the stage
    task automatic wait_capture(input ex_pkg::ex_opc_e exp_opc);
        int cycles;
        cycles = 0;
        do begin
            @(negedge iw_clk);
            cycles++;
        end while (opc_out != exp_opc && cycles < WAIT_LIMIT);
        if (opc_out != exp_opc) begin
            $display("Timeout: opcode %s did not reach the stage output in %0d cycles",
                     exp_opc.name(), cycles);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input ex_pkg::ex_flags_t got,
                               input ex_pkg::ex_flags_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_opc(input string name, input ex_pkg::ex_opc_e got,
                             input ex_pkg::ex_opc_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == 0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors);
            tests_bad++;
        end
        errors = 0;
    endtask

`include "ex_tb_tests.svh"

    initial begin
        seed      = 32'hfe9f_7d8b;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        bank_exp  = '{default: '0};
        iw_rst    = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        opc       = ex_pkg::EX_NOP;
        cc        = ex_pkg::CC_RA;
        pc        = '0;
        src_val   = '0;
        tgt_val   = '0;
        imm12     = '0;
        uimm_bank = 2'd0;
        flags_in  = '0;
        rd_we     = 1'b0;
        repeat (8) @(negedge iw_clk);
        iw_rst = 1'b0;

        reset_state_test();
        end_test("reset_state");
        unsigned_ops_test();
        end_test("unsigned_ops");
        signed_ops_test();
        end_test("signed_ops");
        lui_immediate_test();
        end_test("lui_immediates");
        cond_branch_test();
        end_test("cond_branches");
        stall_flush_test();
        end_test("stall_flush");

        $display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
src/ex_pkg.sv
src/ex_result_if.sv
src/ex_uimm_banks.sv
src/ex_alu.sv
src/ex_branch_unit.sv
src/ex_pipe_reg.sv
src/ex_top.sv
bench/ex_tb.sv

/* run.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -f vlog.f --top-module ex_tb -o ex_sim

sim_out=$(./obj_dir/ex_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'TESTBENCH PASSED'; then
    exit 0
fi
exit 1
